/* hdl/mmu_pkg.sv */
/*
 * shared definitions of the sv39 data-side translation unit:
 * widths, vector types, enums and exception cause codes
 */
`default_nettype none

package mmu_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned VADDR_W     = 39;
    localparam int unsigned PADDR_W     = 56;
    // three 9-bit levels of virtual page number
    localparam int unsigned VPN_W       = 27;
    localparam int unsigned VPN_LVL_W   = 9;
    localparam int unsigned PPN_W       = 44;
    localparam int unsigned PAGE_OFFS_W = 12;
    localparam int unsigned ASID_W      = 4;

    // data tlb size of this build
    localparam int unsigned DTLB_ENTRIES = 4;
    localparam int unsigned DTLB_IDX_W   = (DTLB_ENTRIES > 1) ? $clog2(DTLB_ENTRIES) : 1;

    // --------------------
    // vector types
    // --------------------
    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [VPN_W-1:0]   vpn_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [ASID_W-1:0]  asid_t;

    // pte flags in risc-v order: d a g u x w r v
    typedef logic [7:0] pte_flags_t;

    // bit positions inside pte_flags_t
    localparam int unsigned FLAG_W = 2;
    localparam int unsigned FLAG_U = 4;
    localparam int unsigned FLAG_G = 5;
    localparam int unsigned FLAG_D = 7;

    // --------------------
    // enums
    // --------------------
    typedef enum logic [1:0] {
        PAGE_4K,
        PAGE_2M,
        PAGE_1G
    } page_size_t;

    // privilege encoding as in the privileged spec, no hypervisor level
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_t;

    // exception cause codes
    typedef logic [3:0] exc_cause_t;

    localparam exc_cause_t CAUSE_LOAD_PAGE_FAULT  = 4'd13;
    localparam exc_cause_t CAUSE_STORE_PAGE_FAULT = 4'd15;

endpackage

`default_nettype wire

/* hdl/dtlb.sv */
/*
 * fully associative data tlb with combinational lookup,
 * asid/global match, 4k/2m/1g page matching and flush
 */
`timescale 1ns/1ps
`default_nettype none

module dtlb import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  wire                             clk_i,
    input  wire                             rst_ni,
    input  wire                             flush_i,
    // write port from the refill controller
    input  wire                             we_i,
    input  wire [$clog2(TLB_ENTRIES)-1:0]   widx_i,
    input  vpn_t                            wvpn_i,
    input  asid_t                           wasid_i,
    input  ppn_t                            wppn_i,
    input  pte_flags_t                      wflags_i,
    input  page_size_t                      wsize_i,
    // lookup port
    input  vaddr_t                          lu_vaddr_i,
    input  asid_t                           lu_asid_i,
    output logic [TLB_ENTRIES-1:0]          valid_o,
    output logic                            lu_hit_o,
    output ppn_t                            lu_ppn_o,
    output pte_flags_t                      lu_flags_o,
    output page_size_t                      lu_size_o
);

    // entry storage, only the valid bits are control state
    logic [TLB_ENTRIES-1:0] valid_q;
    vpn_t                   vpn_q   [TLB_ENTRIES];
    asid_t                  asid_q  [TLB_ENTRIES];
    ppn_t                   ppn_q   [TLB_ENTRIES];
    pte_flags_t             flags_q [TLB_ENTRIES];
    page_size_t             size_q  [TLB_ENTRIES];

    vpn_t                   lu_vpn;
    logic [TLB_ENTRIES-1:0] match;

    assign lu_vpn  = lu_vaddr_i[VADDR_W-1:PAGE_OFFS_W];
    assign valid_o = valid_q;

    // --------------------
    // lookup
    // --------------------
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && ((asid_q[i] == lu_asid_i) || flags_q[i][FLAG_G])
                // vpn[2] always compared
                && (vpn_q[i][3*VPN_LVL_W-1:2*VPN_LVL_W] == lu_vpn[3*VPN_LVL_W-1:2*VPN_LVL_W])
                // vpn[1] ignored on giga pages
                && ((size_q[i] == PAGE_1G)
                    || (vpn_q[i][2*VPN_LVL_W-1:VPN_LVL_W] == lu_vpn[2*VPN_LVL_W-1:VPN_LVL_W]))
                // vpn[0] only on 4k pages
                && ((size_q[i] != PAGE_4K)
                    || (vpn_q[i][VPN_LVL_W-1:0] == lu_vpn[VPN_LVL_W-1:0]));
        end
    end

    // lowest matching entry wins, so walk downwards and let later hits override
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_ppn_o   = '0;
        lu_flags_o = '0;
        lu_size_o  = PAGE_4K;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                lu_hit_o   = 1'b1;
                lu_ppn_o   = ppn_q[i];
                lu_flags_o = flags_q[i];
                lu_size_o  = size_q[i];
            end
        end
    end

    // --------------------
    // update
    // --------------------
    // flush beats a write in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[widx_i] <= 1'b1;
        end
    end

    // payload of the selected entry
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            vpn_q[widx_i]   <= wvpn_i;
            asid_q[widx_i]  <= wasid_i;
            ppn_q[widx_i]   <= wppn_i;
            flags_q[widx_i] <= wflags_i;
            size_q[widx_i]  <= wsize_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/tlb_refill_ctrl.sv */
/*
 * refill controller: picks the victim tlb entry for each refill,
 * lowest invalid entry first, else a round-robin pointer
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_refill_ctrl import mmu_pkg::*; (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire                         refill_i,
    input  wire                         flush_i,
    input  wire  [DTLB_ENTRIES-1:0]     entry_valid_i,
    output logic                        we_o,
    output logic [DTLB_IDX_W-1:0]       widx_o
);

    logic [DTLB_IDX_W-1:0] rr_q;
    logic [DTLB_IDX_W-1:0] free_idx;
    logic                  full;

    assign full = &entry_valid_i;

    // lowest invalid entry, downward scan so the smallest index is left
    always_comb begin
        free_idx = '0;
        for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
            if (!entry_valid_i[i]) begin
                free_idx = DTLB_IDX_W'(i);
            end
        end
    end

    // a flush in the same cycle drops the refill
    assign we_o   = refill_i && !flush_i;
    assign widx_o = full ? rr_q : free_idx;

    // --------------------
    // round-robin pointer
    // --------------------
    // only moves when a refill has to evict a valid entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (we_o && full) begin
            if (rr_q == DTLB_IDX_W'(DTLB_ENTRIES - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ls_xlate_stage.sv */
/*
 * load/store translation stage: registers request and tlb result,
 * builds the physical address one cycle later and raises page faults
 */
`timescale 1ns/1ps
`default_nettype none

module ls_xlate_stage import mmu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    input  wire         en_translation_i,
    // cycle 0 request
    input  wire         req_i,
    input  wire         is_store_i,
    input  vaddr_t      vaddr_i,
    // live status, sampled in cycle 1
    input  priv_lvl_t   priv_lvl_i,
    input  wire         sum_i,
    // cycle 0 lookup result from the tlb
    input  wire         lu_hit_i,
    input  ppn_t        lu_ppn_i,
    input  pte_flags_t  lu_flags_i,
    input  page_size_t  lu_size_i,
    // cycle 1 result
    output logic        valid_o,
    output paddr_t      paddr_o,
    output logic        exc_valid_o,
    output exc_cause_t  exc_cause_o,
    output vaddr_t      exc_tval_o
);

    // control part of the pipeline register
    logic       req_q;
    logic       hit_q;
    // payload part
    logic       is_store_q;
    vaddr_t     vaddr_q;
    ppn_t       ppn_q;
    pte_flags_t flags_q;
    page_size_t size_q;

    logic       access_err;
    logic       fault;

    // --------------------
    // pipeline register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= req_i;
            hit_q <= lu_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        is_store_q <= is_store_i;
        vaddr_q    <= vaddr_i;
        ppn_q      <= lu_ppn_i;
        flags_q    <= lu_flags_i;
        size_q     <= lu_size_i;
    end

    // --------------------
    // address
    // --------------------
    always_comb begin
        if (en_translation_i) begin
            // 4k page by default
            paddr_o = {ppn_q, vaddr_q[PAGE_OFFS_W-1:0]};
            // mega page keeps vpn[0] from the virtual address
            if (size_q == PAGE_2M) begin
                paddr_o[20:12] = vaddr_q[20:12];
            end
            // giga page keeps vpn[1] and vpn[0]
            if (size_q == PAGE_1G) begin
                paddr_o[29:12] = vaddr_q[29:12];
            end
        end else begin
            // bare mode, zero extended
            paddr_o = PADDR_W'(vaddr_q);
        end
    end

    // --------------------
    // permission checks
    // --------------------
    // supervisor touching a user page without sum, or user touching a non-user page
    assign access_err = ((priv_lvl_i == PRIV_S) && !sum_i && flags_q[FLAG_U])
                     || ((priv_lvl_i == PRIV_U) && !flags_q[FLAG_U]);

    // stores also need w set and d already set
    assign fault = is_store_q ? (!flags_q[FLAG_W] || !flags_q[FLAG_D] || access_err)
                              : access_err;

    // a miss gives no valid strobe when translating
    assign valid_o     = en_translation_i ? (req_q && hit_q) : req_q;
    assign exc_valid_o = en_translation_i && req_q && hit_q && fault;
    assign exc_cause_o = is_store_q ? CAUSE_STORE_PAGE_FAULT : CAUSE_LOAD_PAGE_FAULT;
    // faulting virtual address
    assign exc_tval_o  = vaddr_q;

endmodule

`default_nettype wire

/* hdl/dmmu_top.sv */
/*
 * data-side sv39 mmu: refill controller, data tlb and
 * load/store translation stage
 */
`timescale 1ns/1ps
`default_nettype none

module dmmu_top import mmu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    // status from the csr file
    input  wire         en_translation_i,
    input  priv_lvl_t   priv_lvl_i,
    input  wire         sum_i,
    input  asid_t       asid_i,
    input  wire         flush_i,
    // load/store request
    input  wire         req_i,
    input  wire         is_store_i,
    input  vaddr_t      vaddr_i,
    // refill strobe, stands in for a page table walker
    input  wire         refill_i,
    input  vpn_t        refill_vpn_i,
    input  asid_t       refill_asid_i,
    input  ppn_t        refill_ppn_i,
    input  pte_flags_t  refill_flags_i,
    input  page_size_t  refill_size_i,
    // cycle 0
    output logic        dtlb_hit_o,
    // cycle 1
    output logic        valid_o,
    output paddr_t      paddr_o,
    output logic        exc_valid_o,
    output exc_cause_t  exc_cause_o,
    output vaddr_t      exc_tval_o
);

    logic                    entry_we;
    logic [DTLB_IDX_W-1:0]   entry_idx;
    logic [DTLB_ENTRIES-1:0] entry_valid;

    logic                    lu_hit;
    ppn_t                    lu_ppn;
    pte_flags_t              lu_flags;
    page_size_t              lu_size;

    // always ready when translation is off
    assign dtlb_hit_o = lu_hit || !en_translation_i;

    // --------------------
    // victim selection
    // --------------------
    tlb_refill_ctrl tlb_refill_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .refill_i      (refill_i),
        .flush_i       (flush_i),
        .entry_valid_i (entry_valid),
        .we_o          (entry_we),
        .widx_o        (entry_idx)
    );

    dtlb #(
        .TLB_ENTRIES (DTLB_ENTRIES)
    ) dtlb_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .we_i       (entry_we),
        .widx_i     (entry_idx),
        .wvpn_i     (refill_vpn_i),
        .wasid_i    (refill_asid_i),
        .wppn_i     (refill_ppn_i),
        .wflags_i   (refill_flags_i),
        .wsize_i    (refill_size_i),
        .lu_vaddr_i (vaddr_i),
        .lu_asid_i  (asid_i),
        .valid_o    (entry_valid),
        .lu_hit_o   (lu_hit),
        .lu_ppn_o   (lu_ppn),
        .lu_flags_o (lu_flags),
        .lu_size_o  (lu_size)
    );

    // --------------------
    // translation stage
    // --------------------
    ls_xlate_stage ls_xlate_stage_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .en_translation_i (en_translation_i),
        .req_i            (req_i),
        .is_store_i       (is_store_i),
        .vaddr_i          (vaddr_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .lu_hit_i         (lu_hit),
        .lu_ppn_i         (lu_ppn),
        .lu_flags_i       (lu_flags),
        .lu_size_i        (lu_size),
        .valid_o          (valid_o),
        .paddr_o          (paddr_o),
        .exc_valid_o      (exc_valid_o),
        .exc_cause_o      (exc_cause_o),
        .exc_tval_o       (exc_tval_o)
    );

endmodule

`default_nettype wire

/* tb/tb_dmmu.sv */
/*
 * testbench of the data-side sv39 mmu: table of refills, flushes
 * and lookups applied in a loop, checked against the page rules
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dmmu import mmu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int OP_REFILL  = 0;
    localparam int OP_FLUSH   = 1;
    localparam int OP_LOOKUP  = 2;

    // --------------------
    // pte flag sets
    // --------------------
    // v r w a d on a supervisor page
    localparam pte_flags_t F_KERN       = 8'hc7;
    // same with u
    localparam pte_flags_t F_USER       = 8'hd7;
    // same with g but no u
    localparam pte_flags_t F_GLOBAL     = 8'he7;
    // user page with d still clear
    localparam pte_flags_t F_USER_CLEAN = 8'h57;
    // read only page with w clear
    localparam pte_flags_t F_RDONLY     = 8'hc3;

    localparam ppn_t PPN_A = 44'h00000012345;
    localparam ppn_t PPN_B = 44'h000000abcdf;
    localparam ppn_t PPN_C = 44'h00fedcba987;
    localparam ppn_t PPN_D = 44'h00000055aa5;
    localparam ppn_t PPN_E = 44'h00000077777;
    localparam ppn_t PPN_F = 44'h0000001f00f;

    typedef struct {
        int         op;
        // lookup stimulus
        logic       en;
        priv_lvl_t  priv;
        logic       sum;
        logic       store;
        asid_t      asid;
        vaddr_t     vaddr;
        int         pass_w;
        // lookup expectations
        logic       exp_hit;
        logic       exp_valid;
        paddr_t     exp_base;
        logic       exp_exc;
        exc_cause_t exp_cause;
        // refill stimulus and the entry it should land in
        vpn_t       vpn;
        ppn_t       ppn;
        pte_flags_t flags;
        page_size_t size;
        int         exp_idx;
    } row_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        en_translation_i;
    priv_lvl_t   priv_lvl_i;
    logic        sum_i;
    asid_t       asid_i;
    logic        flush_i;
    logic        req_i;
    logic        is_store_i;
    vaddr_t      vaddr_i;
    logic        refill_i;
    vpn_t        refill_vpn_i;
    asid_t       refill_asid_i;
    ppn_t        refill_ppn_i;
    pte_flags_t  refill_flags_i;
    page_size_t  refill_size_i;
    logic        dtlb_hit_o;
    logic        valid_o;
    paddr_t      paddr_o;
    logic        exc_valid_o;
    exc_cause_t  exc_cause_o;
    vaddr_t      exc_tval_o;

    row_t        rows[$];
    int          n_rows = 0;
    int          errors = 0;
    logic [31:0] rnd_state = 32'heaa344a3;

    dmmu_top dmmu_top_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic vpn_t page_vpn(input logic [8:0] l2, input logic [8:0] l1,
                                      input logic [8:0] l0);
        return {l2, l1, l0};
    endfunction

    function automatic vaddr_t page_vaddr(input vpn_t vpn);
        return {vpn, 12'h000};
    endfunction

    // ppn on top of a zero page offset
    function automatic paddr_t page_base(input ppn_t ppn);
        return {ppn, 12'h000};
    endfunction

    function automatic row_t empty_row(input int op);
        row_t r;
        r.op = op;
        r.en = 1'b1;
        r.priv = PRIV_S;
        r.sum = 1'b0;
        r.store = 1'b0;
        r.asid = '0;
        r.vaddr = '0;
        r.pass_w = 12;
        r.exp_hit = 1'b0;
        r.exp_valid = 1'b0;
        r.exp_base = '0;
        r.exp_exc = 1'b0;
        r.exp_cause = '0;
        r.vpn = '0;
        r.ppn = '0;
        r.flags = '0;
        r.size = PAGE_4K;
        r.exp_idx = 0;
        return r;
    endfunction

    function automatic void add_refill(input vpn_t vpn, input ppn_t ppn, input pte_flags_t flags,
                                       input page_size_t size, input int exp_idx);
        row_t r;
        r = empty_row(OP_REFILL);
        r.vpn = vpn;
        r.asid = 4'd1;
        r.ppn = ppn;
        r.flags = flags;
        r.size = size;
        r.exp_idx = exp_idx;
        rows.push_back(r);
    endfunction

    function automatic void add_flush();
        rows.push_back(empty_row(OP_FLUSH));
    endfunction

    // pass_w is the number of low vaddr bits that reach paddr untouched
    function automatic void add_lookup(input logic en, input priv_lvl_t priv, input logic sum,
                                       input logic store, input asid_t asid, input vaddr_t va,
                                       input int pass_w, input logic hit, input logic valid,
                                       input paddr_t base, input logic exc,
                                       input exc_cause_t cause);
        row_t r;
        r = empty_row(OP_LOOKUP);
        r.en = en;
        r.priv = priv;
        r.sum = sum;
        r.store = store;
        r.asid = asid;
        r.vaddr = va;
        r.pass_w = pass_w;
        r.exp_hit = hit;
        r.exp_valid = valid;
        r.exp_base = base;
        r.exp_exc = exc;
        r.exp_cause = cause;
        rows.push_back(r);
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // --------------------
    // stimulus table
    // --------------------
    task automatic build_table();
        vpn_t vpn_a = page_vpn(9'd1, 9'd2, 9'd3);
        vpn_t vpn_b = page_vpn(9'd1, 9'd5, 9'd0);
        vpn_t vpn_c = page_vpn(9'd2, 9'd0, 9'd0);
        vpn_t vpn_d = page_vpn(9'd3, 9'd1, 9'd1);
        vpn_t vpn_e = page_vpn(9'd4, 9'd4, 9'd4);
        vpn_t vpn_f = page_vpn(9'd5, 9'd5, 9'd5);
        vpn_t vpn_x = page_vpn(9'h1ab, 9'd0, 9'd0);
        // bare mode on an empty tlb, then a plain miss
        add_lookup(1'b0, PRIV_M, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_x), 30, 1'b1, 1'b1,
                   PADDR_W'(page_vaddr(vpn_x)), 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_a), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        // fill all four entries with every page kind
        add_refill(vpn_a, PPN_A, F_KERN, PAGE_4K, 0);
        add_refill(vpn_b, PPN_B, F_USER, PAGE_2M, 1);
        add_refill(vpn_c, PPN_C, F_GLOBAL, PAGE_1G, 2);
        add_refill(vpn_d, PPN_D, F_USER_CLEAN, PAGE_4K, 3);
        // bare mode ignores a hit on a page that would fault a u mode store
        add_lookup(1'b0, PRIV_U, 1'b0, 1'b1, 4'd1, page_vaddr(vpn_a), 12, 1'b1, 1'b1,
                   PADDR_W'(page_vaddr(vpn_a)), 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_a), 12, 1'b1, 1'b1,
                   page_base(PPN_A), 1'b0, '0);
        // user page from s mode first without and then with sum
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_b), 21, 1'b1, 1'b1,
                   page_base(PPN_B), 1'b1, CAUSE_LOAD_PAGE_FAULT);
        add_lookup(1'b1, PRIV_S, 1'b1, 1'b0, 4'd1, page_vaddr(vpn_b), 21, 1'b1, 1'b1,
                   page_base(PPN_B), 1'b0, '0);
        add_lookup(1'b1, PRIV_U, 1'b0, 1'b1, 4'd1, page_vaddr(vpn_b), 21, 1'b1, 1'b1,
                   page_base(PPN_B), 1'b0, '0);
        // under another asid the global giga page hits and the private page misses
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd2, page_vaddr(vpn_c), 30, 1'b1, 1'b1,
                   page_base(PPN_C), 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd2, page_vaddr(vpn_a), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        // store with d clear and u mode on a supervisor page
        add_lookup(1'b1, PRIV_U, 1'b0, 1'b1, 4'd1, page_vaddr(vpn_d), 12, 1'b1, 1'b1,
                   page_base(PPN_D), 1'b1, CAUSE_STORE_PAGE_FAULT);
        add_lookup(1'b1, PRIV_U, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_d), 12, 1'b1, 1'b1,
                   page_base(PPN_D), 1'b0, '0);
        add_lookup(1'b1, PRIV_U, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_a), 12, 1'b1, 1'b1,
                   page_base(PPN_A), 1'b1, CAUSE_LOAD_PAGE_FAULT);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_x), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        // the fifth refill into the full tlb evicts entry 0
        add_refill(vpn_e, PPN_E, F_RDONLY, PAGE_4K, 0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_a), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b1, 4'd1, page_vaddr(vpn_e), 12, 1'b1, 1'b1,
                   page_base(PPN_E), 1'b1, CAUSE_STORE_PAGE_FAULT);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_e), 12, 1'b1, 1'b1,
                   page_base(PPN_E), 1'b0, '0);
        // flush empties everything and the next refill goes to entry 0
        add_flush();
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_b), 21, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_c), 30, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_d), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_e), 12, 1'b0, 1'b0,
                   '0, 1'b0, '0);
        add_refill(vpn_f, PPN_F, F_KERN, PAGE_4K, 0);
        add_lookup(1'b1, PRIV_S, 1'b0, 1'b0, 4'd1, page_vaddr(vpn_f), 12, 1'b1, 1'b1,
                   page_base(PPN_F), 1'b0, '0);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        row_t        row;
        logic [31:0] offs_mask;
        vaddr_t      va;
        paddr_t      exp_pa;
        string       tag;
        rst_ni = 1'b0;
        en_translation_i = 1'b0;
        priv_lvl_i = PRIV_M;
        sum_i = 1'b0;
        asid_i = '0;
        flush_i = 1'b0;
        req_i = 1'b0;
        is_store_i = 1'b0;
        vaddr_i = '0;
        refill_i = 1'b0;
        refill_vpn_i = '0;
        refill_asid_i = '0;
        refill_ppn_i = '0;
        refill_flags_i = '0;
        refill_size_i = PAGE_4K;
        build_table();
        n_rows = rows.size();
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            row = rows[i];
            tag = $sformatf("row %0d", i);
            @(posedge clk_i);
            req_i <= 1'b0;
            refill_i <= 1'b0;
            flush_i <= 1'b0;
            if (row.op == OP_REFILL) begin
                refill_i <= 1'b1;
                refill_vpn_i <= row.vpn;
                refill_asid_i <= row.asid;
                refill_ppn_i <= row.ppn;
                refill_flags_i <= row.flags;
                refill_size_i <= row.size;
                @(negedge clk_i);
                check_value(64'(dmmu_top_i.entry_idx), 64'(row.exp_idx), {tag, " victim"});
            end else if (row.op == OP_FLUSH) begin
                flush_i <= 1'b1;
            end else begin
                // random offset, and on large pages the passed vpn levels too
                rnd_state = next_rand(rnd_state);
                offs_mask = (32'd1 << row.pass_w) - 32'd1;
                va = (row.vaddr & ~VADDR_W'(offs_mask)) | VADDR_W'(rnd_state & offs_mask);
                exp_pa = (row.exp_base & ~PADDR_W'(offs_mask))
                       | PADDR_W'(rnd_state & offs_mask);
                en_translation_i <= row.en;
                priv_lvl_i <= row.priv;
                sum_i <= row.sum;
                asid_i <= row.asid;
                is_store_i <= row.store;
                vaddr_i <= va;
                req_i <= 1'b1;
                @(negedge clk_i);
                check_value(64'(dtlb_hit_o), 64'(row.exp_hit), {tag, " dtlb_hit"});
                // status stays put through the result cycle
                @(posedge clk_i);
                req_i <= 1'b0;
                @(negedge clk_i);
                check_value(64'(valid_o), 64'(row.exp_valid), {tag, " valid"});
                check_value(64'(exc_valid_o), 64'(row.exp_exc), {tag, " exc_valid"});
                if (row.exp_valid) begin
                    check_value(64'(paddr_o), 64'(exp_pa), {tag, " paddr"});
                end
                if (row.exp_exc) begin
                    check_value(64'(exc_cause_o), 64'(row.exp_cause), {tag, " cause"});
                    check_value(64'(exc_tval_o), 64'(va), {tag, " tval"});
                end
            end
        end
        @(posedge clk_i);
        $display("checks done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // at most two cycles per row plus reset and slack
    initial begin
        wait (n_rows > 0);
        #((2 * n_rows + 20) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/mmu_pkg.sv
hdl/dtlb.sv
hdl/tlb_refill_ctrl.sv
hdl/ls_xlate_stage.sv
hdl/dmmu_top.sv
tb/tb_dmmu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dmmu testbench with Verilator.
# Exit status is 0 only when the simulation log holds no failure.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module tb_dmmu \
    -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_dmmu" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
